// ==== cic_cen_gen.sv ====
`timescale 1ns/10ps

module cic_cen_gen #(
    parameter int RATE = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] div,
    input  logic       div_load,
    output logic       cen_in,
    output logic       cen_out
);

    localparam int RW = (RATE > 1) ? $clog2(RATE) : 1;     // Phase counter width.
    localparam logic [RW-1:0] RLAST = RW'(RATE - 1);       // Last input phase.

    logic [7:0]    cnt;                             // Cycles left to the next input sample.
    logic [RW-1:0] phase;                           // Input samples in this output period.
    logic          tick;                            // Divider wraps this cycle.

    assign tick = (cnt == 8'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= div;                         // First pulse div+1 cycles after reset.
            phase   <= '0;
            cen_in  <= 1'b0;
            cen_out <= 1'b0;
        end else if (div_load) begin
            cnt     <= div;                         // New period starts from a full count.
            cen_in  <= 1'b0;
            cen_out <= 1'b0;
        end else begin
            cen_in  <= tick;
            cen_out <= tick && (phase == RLAST);    // Rides on the wrapping input pulse.
            if (tick) begin
                cnt <= div;
                if (phase == RLAST) begin
                    phase <= '0;
                end else begin
                    phase <= phase + 1'b1;
                end
            end else begin
                cnt <= cnt - 8'd1;
            end
        end
    end

endmodule

// ==== cic_cfg_regs.sv ====
`timescale 1ns/10ps

module cic_cfg_regs
    import cic_decim_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cfg_wr_t  cfg_wr,
    output cic_cfg_t cfg,
    output logic     div_load
);

    logic div_hit;                                  // Write to the divider register.

    assign div_hit = cfg_wr.we && (cfg_wr.addr == REG_DIV);

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg      <= CFG_RESET;                  // Defaults give unity gain.
            div_load <= 1'b0;
        end else begin
            div_load <= div_hit;                    // Restart the divider next cycle.
            if (cfg_wr.we) begin
                case (cfg_wr.addr)
                    REG_DIV: begin
                        cfg.div <= cfg_wr.data;     // Full byte.
                    end
                    REG_SHIFT: begin
                        cfg.shift <= cfg_wr.data[2:0]; // Upper bits dropped.
                    end
                    REG_CTRL: begin
                        cfg.bypass <= cfg_wr.data[0];
                    end
                    default: begin
                        // Address 3 has no register behind it.
                    end
                endcase
            end
        end
    end

endmodule

// ==== cic_comb.sv ====
`timescale 1ns/10ps

module cic_comb
    import cic_decim_pkg::*;
#(
    parameter int DELAY = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  acc_t comb_in,
    output acc_t comb_out
);

    acc_t hist [DELAY];                             // Past inputs, oldest at the end.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DELAY; i++) begin
                hist[i] <= '0;
            end
            comb_out <= '0;
        end else if (cen) begin
            hist[0] <= comb_in;
            for (int i = 1; i < DELAY; i++) begin
                hist[i] <= hist[i-1];               // Shift toward the oldest slot.
            end
            comb_out <= comb_in - hist[DELAY-1];    // Wraps like the integrators.
        end
    end

endmodule

// ==== cic_decim.f ====
cic_decim_pkg.sv
cic_cfg_regs.sv
cic_cen_gen.sv
cic_comb.sv
cic_decim.sv
cic_out_scale.sv
cic_decim_top.sv
cic_decim_tb.sv

// ==== cic_decim.sv ====
`timescale 1ns/10ps

module cic_decim
    import cic_decim_pkg::*;
#(
    parameter int RATE   = 4,
    parameter int STAGES = 2,
    parameter int DELAY  = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen_in,
    input  logic    cen_out,
    input  sample_t snd_in,
    output acc_t    acc
);

    localparam int GROWTH = STAGES * $clog2(RATE * DELAY); // Bit growth of the filter.

    acc_t in_ext;                                   // Input at accumulator width.
    acc_t integ [STAGES];                           // Integrator chain.
    acc_t dec_q;                                    // Decimation latch.
    acc_t comb_q [STAGES];                          // Comb chain outputs.

    if ($bits(acc_t) < SAMPLE_W + GROWTH) begin : g_width_chk
        $error("acc_t is too narrow for RATE, STAGES and DELAY");
    end

    assign in_ext = acc_t'(snd_in);                 // Signed cast, sign-extends.

    // Integrators run at the input rate.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < STAGES; k++) begin
                integ[k] <= '0;
            end
        end else if (cen_in) begin
            integ[0] <= integ[0] + in_ext;          // Overflow wraps, combs undo it.
            for (int k = 1; k < STAGES; k++) begin
                integ[k] <= integ[k] + integ[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_q <= '0;
        end else if (cen_out) begin
            dec_q <= integ[STAGES-1];               // Keep one of every RATE values.
        end
    end

    for (genvar k = 0; k < STAGES; k++) begin : g_comb
        if (k == 0) begin : g_first
            cic_comb #(
                .DELAY    (DELAY)
            ) cic_comb_i (
                .clk      (clk),
                .rst      (rst),
                .cen      (cen_out),
                .comb_in  (dec_q),
                .comb_out (comb_q[k])
            );
        end else begin : g_next
            cic_comb #(
                .DELAY    (DELAY)
            ) cic_comb_i (
                .clk      (clk),
                .rst      (rst),
                .cen      (cen_out),
                .comb_in  (comb_q[k-1]),
                .comb_out (comb_q[k])
            );
        end
    end

    assign acc = comb_q[STAGES-1];                  // Full precision, gain (RATE*DELAY)**STAGES.

endmodule

// ==== cic_decim_pkg.sv ====
package cic_decim_pkg;

    localparam int SAMPLE_W = 16;                   // Audio sample width.
    localparam int ACC_W    = 20;                   // 16 + N*log2(R*M) for N=2, R=4, M=1.

    typedef logic signed [SAMPLE_W-1:0] sample_t;   // One audio sample.
    typedef logic signed [ACC_W-1:0]    acc_t;      // Full-precision filter word.

    // Live settings seen by the datapath.
    typedef struct packed {
        logic [7:0] div;                            // Input enable period minus one.
        logic [2:0] shift;                          // Right shift on the accumulator.
        logic       bypass;                         // Skip the filter.
    } cic_cfg_t;

    // Register write port, one word.
    typedef struct packed {
        logic       we;                             // Write strobe, one cycle.
        logic [1:0] addr;                           // Register address.
        logic [7:0] data;                           // Write data.
    } cfg_wr_t;

    localparam logic [1:0] REG_DIV   = 2'd0;        // Input rate divider.
    localparam logic [1:0] REG_SHIFT = 2'd1;        // Output shift, bits 2:0.
    localparam logic [1:0] REG_CTRL  = 2'd2;        // Bit 0 is bypass.

    // Unity DC gain for the default filter: gain 16, shift 4.
    localparam cic_cfg_t CFG_RESET = '{
        div:    8'd3,
        shift:  3'd4,
        bypass: 1'b0
    };

endpackage

// ==== cic_decim_tb.sv ====
`timescale 1ns/10ps

module cic_decim_tb
    import cic_decim_pkg::*;
();

    localparam int RATE    = 4;                     // Matches the DUT default.
    localparam int RST_DIV = 3;                     // Divider value after reset.
    localparam int SETTLE  = 8;                     // Valid pulses before the checked one.
    localparam int HOLD    = 4;                     // Extra pulses checked on hold entries.

    // One table row with stimulus and the expected filtered output.
    typedef struct {
        string      name;
        logic [7:0] div;
        logic [2:0] shift;
        logic       bypass;
        logic       wr3;                            // Also write the unused address.
        logic       hold;                           // Check every pulse after settling.
        sample_t    snd;
        sample_t    exp_out;
    } test_t;

    logic    clk;
    logic    rst;
    cfg_wr_t cfg_wr;
    sample_t snd_in;
    logic    in_strobe;
    sample_t snd_out;
    logic    snd_valid;

    test_t   tests [$];                             // Stimulus table.
    longint  run_limit;                             // Watchdog limit in ns.

    cic_decim_top cic_decim_top_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .snd_in    (snd_in),
        .in_strobe (in_strobe),
        .snd_out   (snd_out),
        .snd_valid (snd_valid)
    );

    always #5 clk = ~clk;                           // 10 ns period.

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t exp_v, input sample_t act_v);
        if (act_v !== exp_v) begin
            fail_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp_v, act_v));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            fail_run($sformatf("FAILED %s: expected %b, actual %b", name, exp_v, act_v));
        end
    endtask

    // Clocks from one pulse to the next on in_strobe or snd_valid.
    task automatic check_strobe_gap(input string name, input bit on_valid, input int exp_gap);
        int gap;
        do begin
            @(negedge clk);
        end while (!(on_valid ? snd_valid : in_strobe));
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
        end while (!(on_valid ? snd_valid : in_strobe));
        if (gap != exp_gap) begin
            fail_run($sformatf("FAILED %s: expected gap %0d, actual gap %0d",
                               name, exp_gap, gap));
        end
    endtask

    task automatic wait_valid();
        do begin
            @(negedge clk);                         // Outputs are stable here.
        end while (!snd_valid);
    endtask

    task automatic write_reg(input logic [1:0] wr_addr, input logic [7:0] wr_data);
        @(posedge clk);
        #1;
        cfg_wr.we   = 1'b1;
        cfg_wr.addr = wr_addr;
        cfg_wr.data = wr_data;
        @(posedge clk);                             // Captured on this edge.
        #1;
        cfg_wr = '0;
    endtask

    task automatic add_test(input string name, input logic [7:0] div, input logic [2:0] shift,
                            input logic bypass, input logic wr3, input logic hold,
                            input sample_t snd, input sample_t exp_out);
        test_t t;
        t = '{name, div, shift, bypass, wr3, hold, snd, exp_out};
        tests.push_back(t);
    endtask

    task automatic run_test(input test_t t);
        @(posedge clk);
        #1;
        snd_in = t.snd;                             // Held for the whole entry.
        write_reg(REG_DIV, t.div);
        write_reg(REG_SHIFT, {5'd0, t.shift});
        write_reg(REG_CTRL, {7'd0, t.bypass});
        if (t.wr3) begin
            write_reg(2'd3, 8'hff);                 // Would change every field if decoded.
        end
        repeat (SETTLE) wait_valid();
        check_sample(t.name, t.exp_out, snd_out);
        if (t.hold) begin
            repeat (HOLD) begin
                wait_valid();
                check_sample(t.name, t.exp_out, snd_out);
            end
        end
        check_strobe_gap({t.name, " in_strobe"}, 1'b0, int'(t.div) + 1);
        check_strobe_gap({t.name, " snd_valid"}, 1'b1, RATE * (int'(t.div) + 1));
    endtask

    initial begin
        wait (run_limit > 0);
        #(run_limit);
        fail_run("Timeout: the DUT stopped producing in_strobe or snd_valid pulses");
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        cfg_wr    = '0;
        snd_in    = '0;
        run_limit = 0;

        // Expected output is 16 times the input, shifted right and clamped.
        // Bypass passes the input.
        add_test("reset_pos",     8'd3, 3'd4, 1'b0, 1'b0, 1'b1,   1234,   1234);
        add_test("reset_neg",     8'd3, 3'd4, 1'b0, 1'b0, 1'b1,  -2500,  -2500);
        add_test("reset_zero",    8'd3, 3'd4, 1'b0, 1'b0, 1'b1,      0,      0);
        add_test("shift2_gain",   8'd3, 3'd2, 1'b0, 1'b0, 1'b0,   1000,   4000);
        add_test("shift2_sat_hi", 8'd3, 3'd2, 1'b0, 1'b0, 1'b0,  10000,  32767);
        add_test("shift2_sat_lo", 8'd3, 3'd2, 1'b0, 1'b0, 1'b0, -10000, -32768);
        add_test("bypass_pos",    8'd3, 3'd4, 1'b1, 1'b0, 1'b1,  12345,  12345);
        add_test("bypass_neg",    8'd3, 3'd4, 1'b1, 1'b0, 1'b1,   -321,   -321);
        add_test("div0",          8'd0, 3'd4, 1'b0, 1'b0, 1'b0,    777,    777);
        add_test("div1",          8'd1, 3'd4, 1'b0, 1'b0, 1'b0,   -777,   -777);
        add_test("div7",          8'd7, 3'd4, 1'b0, 1'b0, 1'b0,   4321,   4321);
        add_test("addr3_ignored", 8'd3, 3'd4, 1'b0, 1'b1, 1'b1,   1234,   1234);

        run_limit = 1000;                           // Reset and idle window.
        foreach (tests[i]) begin
            // About 16 output periods per entry plus the writes.
            run_limit += 20 * RATE * (int'(tests[i].div) + 1) * 10 + 200;
        end

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // First output enable lands RATE*(div+1) edges after release.
        @(posedge clk);
        repeat (RATE * (RST_DIV + 1)) begin
            @(negedge clk);
            check_flag("reset_idle snd_valid", 1'b0, snd_valid);
            check_sample("reset_idle snd_out", 16'sd0, snd_out);
        end
        @(negedge clk);
        check_flag("first_valid", 1'b1, snd_valid);
        check_sample("first_valid snd_out", 16'sd0, snd_out);

        foreach (tests[i]) begin
            run_test(tests[i]);
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== cic_decim_top.sv ====
`timescale 1ns/10ps

module cic_decim_top
    import cic_decim_pkg::*;
#(
    parameter int RATE   = 4,
    parameter int STAGES = 2,
    parameter int DELAY  = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  cfg_wr_t cfg_wr,
    input  sample_t snd_in,
    output logic    in_strobe,
    output sample_t snd_out,
    output logic    snd_valid
);

    cic_cfg_t cfg;                                  // Live settings.
    logic     div_load;                             // Divider restart.
    logic     cen_in;                               // Input sample enable.
    logic     cen_out;                              // Output sample enable.
    acc_t     acc;                                  // Filter output.

    assign in_strobe = cen_in;                      // Source presents the next sample.

    cic_cfg_regs cic_cfg_regs_i (
        .clk      (clk),
        .rst      (rst),
        .cfg_wr   (cfg_wr),
        .cfg      (cfg),
        .div_load (div_load)
    );

    cic_cen_gen #(
        .RATE     (RATE)
    ) cic_cen_gen_i (
        .clk      (clk),
        .rst      (rst),
        .div      (cfg.div),
        .div_load (div_load),
        .cen_in   (cen_in),
        .cen_out  (cen_out)
    );

    cic_decim #(
        .RATE     (RATE),
        .STAGES   (STAGES),
        .DELAY    (DELAY)
    ) cic_decim_i (
        .clk      (clk),
        .rst      (rst),
        .cen_in   (cen_in),
        .cen_out  (cen_out),
        .snd_in   (snd_in),
        .acc      (acc)
    );

    cic_out_scale cic_out_scale_i (
        .clk       (clk),
        .rst       (rst),
        .cen_out   (cen_out),
        .cfg       (cfg),
        .snd_in    (snd_in),
        .acc       (acc),
        .snd_out   (snd_out),
        .snd_valid (snd_valid)
    );

endmodule

// ==== cic_out_scale.sv ====
`timescale 1ns/10ps

module cic_out_scale
    import cic_decim_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cen_out,
    input  cic_cfg_t cfg,
    input  sample_t  snd_in,
    input  acc_t     acc,
    output sample_t  snd_out,
    output logic     snd_valid
);

    localparam acc_t SAT_HI = acc_t'(32767);        // Largest sample.
    localparam acc_t SAT_LO = acc_t'(-32768);       // Smallest sample.

    acc_t    shifted;                               // Accumulator after the shift.
    sample_t sat_val;                               // Clamped to sample range.

    assign shifted = acc >>> cfg.shift;             // Arithmetic, keeps the sign.

    always_comb begin
        if (shifted > SAT_HI) begin
            sat_val = sample_t'(SAT_HI);
        end else if (shifted < SAT_LO) begin
            sat_val = sample_t'(SAT_LO);
        end else begin
            sat_val = sample_t'(shifted);           // Fits, drop the top bits.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_out   <= '0;
            snd_valid <= 1'b0;
        end else begin
            snd_valid <= cen_out;                   // One cycle after the output enable.
            if (cen_out) begin
                snd_out <= cfg.bypass ? snd_in : sat_val;  // Bypass resamples the raw input.
            end
        end
    end

endmodule
